// ==== source/ngram_pkg.sv ====
`default_nettype none

package ngram_pkg;

    // loop bounds, counters and source addresses
    localparam int ADDR_W = 20;
    // source words and window sums
    localparam int DATA_W = 32;
    // destination slot index, caps addr_i at 255
    localparam int DST_ADDR_W = 8;
    localparam int DST_DEPTH = 2 ** DST_ADDR_W;
    // only the low part of the source space is built
    localparam int SRC_DEPTH = 1024;
    localparam int SRC_IDX_W = $clog2(SRC_DEPTH);
    // address step from one window to the next
    localparam int STRIDE = 3;
    // writer busy time per commit
    localparam int WRITE_CYCLES = 2;
    localparam int WR_CNT_W = $clog2(WRITE_CYCLES + 1);

    typedef logic [ADDR_W-1:0]     addr_t;
    typedef logic [DATA_W-1:0]     word_t;
    typedef logic [DST_ADDR_W-1:0] dst_addr_t;
    typedef logic [WR_CNT_W-1:0]   wr_cnt_t;

    // result writer FSM
    typedef enum logic [1:0] {WR_IDLE, WR_BUSY, WR_DONE} wr_state_t;

endpackage

`default_nettype wire

// ==== source/agu_next.sv ====
`timescale 1ns/1ps
`default_nettype none

module agu_next (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     start,
    input  wire                     en,
    input  wire ngram_pkg::addr_t   ini,
    input  wire ngram_pkg::addr_t   fin,
    output ngram_pkg::addr_t        data,
    output logic                    last,
    output logic                    next
);

    // high from the load until the final step
    logic running;

    // final step, data already sits on the bound
    assign last = running & en & (data == fin);
    // every other step
    assign next = running & en & ~last;

    ////////////////////
    // counter and run flag
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            running <= 1'b0;
            data    <= '0;
        end else if (start) begin
            running <= 1'b1;
            data    <= ini;
        end else if (last) begin
            // data parks on fin
            running <= 1'b0;
        end else if (next) begin
            data <= data + ngram_pkg::addr_t'(1);
        end
    end

endmodule

`default_nettype wire

// ==== source/exe_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module exe_ctrl (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     s_init,
    input  wire                     out_busy,
    input  wire                     out_fin,
    input  wire ngram_pkg::addr_t   addr_i,
    input  wire ngram_pkg::addr_t   addr_j,
    output logic                    s_fin,
    output logic                    k_init,
    output logic                    k_fin,
    output logic                    exec,
    output ngram_pkg::addr_t        exec_src_addr
);

    logic               last_i;
    logic               last_j;
    logic               next_i;
    ngram_pkg::addr_t   i;
    ngram_pkg::addr_t   j;
    logic               s_init_delay;
    logic               k_init_next;
    logic               start;
    logic               s_fin_period;
    logic               last_out_fin;

    ////////////////////
    // window start
    ////////////////////
    // first window one cycle after s_init
    always_ff @(posedge clk) begin
        if (rst) begin
            s_init_delay <= 1'b0;
        end else begin
            s_init_delay <= s_init;
        end
    end

    // later windows come from k_init_next
    // held back while the writer is busy
    assign k_init = (s_init_delay | k_init_next) & ~out_busy;

    // exec covers the j run, start kicks the j counter
    always_ff @(posedge clk) begin
        if (rst) begin
            exec  <= 1'b0;
            start <= 1'b0;
        end else begin
            exec  <= k_init | (exec & ~last_j);
            start <= k_init;
        end
    end

    ////////////////////
    // loop counters
    ////////////////////
    // outer loop, one step per window
    agu_next l_i (
        .clk   (clk),
        .rst   (rst),
        .start (s_init),
        .en    (last_j),
        .ini   ('0),
        .fin   (addr_i),
        .data  (i),
        .last  (last_i),
        .next  (next_i)
    );

    // inner loop, restarted for each window
    agu_next l_j (
        .clk   (clk),
        .rst   (rst),
        .start (start),
        .en    (1'b1),
        .ini   ('0),
        .fin   (addr_j),
        .data  (j),
        .last  (last_j),
        .next  ()
    );

    // windows overlap when addr_j reaches STRIDE
    assign exec_src_addr = ngram_pkg::addr_t'(i * ngram_pkg::STRIDE + j);

    ////////////////////
    // window end
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            k_fin <= 1'b0;
        end else begin
            k_fin <= last_j;
        end
    end

    // pending window start, set on next_i and kept while out_busy
    always_ff @(posedge clk) begin
        if (rst) begin
            k_init_next <= 1'b0;
        end else if (~out_busy | next_i) begin
            k_init_next <= next_i & ~s_init;
        end
    end

    ////////////////////
    // run finish
    ////////////////////
    // out_fin together with k_fin closes the previous commit, not the last one
    assign last_out_fin = out_fin & ~k_fin;

    always_ff @(posedge clk) begin
        if (rst) begin
            s_fin_period <= 1'b0;
        end else if (last_i) begin
            s_fin_period <= 1'b1;
        end else if (last_out_fin) begin
            s_fin_period <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            s_fin <= 1'b0;
        end else begin
            s_fin <= s_fin_period & last_out_fin;
        end
    end

endmodule

`default_nettype wire

// ==== source/src_buff.sv ====
`timescale 1ns/1ps
`default_nettype none

module src_buff (
    input  wire                     clk,
    input  wire                     we_i,
    input  wire ngram_pkg::addr_t   waddr_i,
    input  wire ngram_pkg::word_t   wdata_i,
    input  wire ngram_pkg::addr_t   raddr_i,
    output ngram_pkg::word_t        rdata_o
);

    ngram_pkg::word_t mem [ngram_pkg::SRC_DEPTH];

    // host load port, one word per cycle
    // upper address bits fold onto the built depth
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i[ngram_pkg::SRC_IDX_W-1:0]] <= wdata_i;
        end
    end

    // execution read, one cycle latency
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i[ngram_pkg::SRC_IDX_W-1:0]];
    end

endmodule

`default_nettype wire

// ==== source/window_acc.sv ====
`timescale 1ns/1ps
`default_nettype none

module window_acc (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     k_init_i,
    input  wire                     k_fin_i,
    input  wire                     exec_i,
    input  wire ngram_pkg::word_t   word_i,
    output logic                    sum_valid_o,
    output ngram_pkg::word_t        sum_o
);

    // exec lined up with the buffer read latency
    logic               exec_d;
    logic               exec_dd;
    // word on word_i belongs to a j step
    logic               word_live;
    ngram_pkg::word_t   acc_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            exec_d  <= 1'b0;
            exec_dd <= 1'b0;
        end else begin
            exec_d  <= exec_i;
            exec_dd <= exec_d;
        end
    end

    // first exec cycle has no j step yet, so its word is skipped
    assign word_live = exec_d & exec_dd;

    ////////////////////
    // running sum
    ////////////////////
    // clear wins, k_init can land on the last word of the prior window
    always_ff @(posedge clk) begin
        if (k_init_i) begin
            acc_q <= '0;
        end else if (word_live) begin
            acc_q <= acc_q + word_i;
        end
    end

    // sum includes the word arriving with k_fin, wraps mod 2^32
    assign sum_o       = acc_q + word_i;
    assign sum_valid_o = k_fin_i & word_live;

endmodule

`default_nettype wire

// ==== source/result_writer.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_writer (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         s_init_i,
    input  wire                         sum_valid_i,
    input  wire ngram_pkg::word_t       sum_i,
    input  wire ngram_pkg::dst_addr_t   rd_addr_i,
    output ngram_pkg::word_t            rd_data_o,
    output logic                        out_busy_o,
    output logic                        out_fin_o
);

    ngram_pkg::wr_state_t   state_q;
    ngram_pkg::wr_cnt_t     cnt_q;
    ngram_pkg::dst_addr_t   wr_ptr;
    logic                   commit;
    ngram_pkg::word_t       dst_mem [ngram_pkg::DST_DEPTH];

    // a sum can arrive in WR_DONE, never in WR_BUSY
    assign commit = sum_valid_i & (state_q != ngram_pkg::WR_BUSY);

    ////////////////////
    // writer FSM
    ////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= ngram_pkg::WR_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                ngram_pkg::WR_IDLE, ngram_pkg::WR_DONE: begin
                    cnt_q <= '0;
                    if (commit) begin
                        state_q <= ngram_pkg::WR_BUSY;
                    end else begin
                        state_q <= ngram_pkg::WR_IDLE;
                    end
                end
                ngram_pkg::WR_BUSY: begin
                    // busy for WRITE_CYCLES cycles
                    cnt_q <= cnt_q + ngram_pkg::wr_cnt_t'(1);
                    if (cnt_q == ngram_pkg::wr_cnt_t'(ngram_pkg::WRITE_CYCLES - 1)) begin
                        state_q <= ngram_pkg::WR_DONE;
                    end
                end
                default: begin
                    state_q <= ngram_pkg::WR_IDLE;
                end
            endcase
        end
    end

    assign out_busy_o = (state_q == ngram_pkg::WR_BUSY);
    assign out_fin_o  = (state_q == ngram_pkg::WR_DONE);

    // slot pointer, back to 0 for every run
    always_ff @(posedge clk) begin
        if (rst || s_init_i) begin
            wr_ptr <= '0;
        end else if (commit) begin
            wr_ptr <= wr_ptr + ngram_pkg::dst_addr_t'(1);
        end
    end

    ////////////////////
    // destination memory
    ////////////////////
    always_ff @(posedge clk) begin
        if (commit) begin
            dst_mem[wr_ptr] <= sum_i;
        end
    end

    // host readback, data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data_o <= dst_mem[rd_addr_i];
    end

endmodule

`default_nettype wire

// ==== source/ngram_exec_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module ngram_exec_top (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         ld_we_i,
    input  wire ngram_pkg::addr_t       ld_addr_i,
    input  wire ngram_pkg::word_t       ld_data_i,
    input  wire                         s_init_i,
    input  wire ngram_pkg::addr_t       addr_i_i,
    input  wire ngram_pkg::addr_t       addr_j_i,
    input  wire ngram_pkg::dst_addr_t   rd_addr_i,
    output ngram_pkg::word_t            rd_data_o,
    output logic                        s_fin_o
);

    // sequencer strobes
    logic               k_init;
    logic               k_fin;
    logic               exec;
    ngram_pkg::addr_t   exec_src_addr;
    // data path
    ngram_pkg::word_t   rd_word;
    logic               sum_valid;
    ngram_pkg::word_t   sum;
    // writer feedback
    logic               out_busy;
    logic               out_fin;

    exe_ctrl u_ctrl (
        .clk           (clk),
        .rst           (rst),
        .s_init        (s_init_i),
        .out_busy      (out_busy),
        .out_fin       (out_fin),
        .addr_i        (addr_i_i),
        .addr_j        (addr_j_i),
        .s_fin         (s_fin_o),
        .k_init        (k_init),
        .k_fin         (k_fin),
        .exec          (exec),
        .exec_src_addr (exec_src_addr)
    );

    src_buff u_src (
        .clk     (clk),
        .we_i    (ld_we_i),
        .waddr_i (ld_addr_i),
        .wdata_i (ld_data_i),
        .raddr_i (exec_src_addr),
        .rdata_o (rd_word)
    );

    window_acc u_acc (
        .clk         (clk),
        .rst         (rst),
        .k_init_i    (k_init),
        .k_fin_i     (k_fin),
        .exec_i      (exec),
        .word_i      (rd_word),
        .sum_valid_o (sum_valid),
        .sum_o       (sum)
    );

    result_writer u_wr (
        .clk         (clk),
        .rst         (rst),
        .s_init_i    (s_init_i),
        .sum_valid_i (sum_valid),
        .sum_i       (sum),
        .rd_addr_i   (rd_addr_i),
        .rd_data_o   (rd_data_o),
        .out_busy_o  (out_busy),
        .out_fin_o   (out_fin)
    );

endmodule

`default_nettype wire

// ==== tests/ngram_exec_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module ngram_exec_props (
    input wire clk,
    input wire rst,
    input wire k_init,
    input wire out_busy,
    input wire exec,
    input wire s_fin,
    input wire sum_valid,
    input wire out_fin
);

    // back-pressure keeps every window sum off a busy writer
    sum_not_busy: assert property (@(posedge clk) disable iff (rst)
        !(sum_valid && out_busy))
        else $error("sum_valid arrived while out_busy was high");

    // j run opens right after the window start and outlives the start cycle
    exec_after_k_init: assert property (@(posedge clk) disable iff (rst)
        k_init |=> exec ##1 exec)
        else $error("exec not held for two cycles after k_init");

    // busy for WRITE_CYCLES cycles then the done pulse
    fin_after_sum: assert property (@(posedge clk) disable iff (rst)
        sum_valid |-> ##(ngram_pkg::WRITE_CYCLES + 1) out_fin)
        else $error("out_fin missing after a committed sum");

    s_fin_one_cycle: assert property (@(posedge clk) disable iff (rst)
        s_fin |=> !s_fin)
        else $error("s_fin held high for more than one cycle");

endmodule

// sequencer side
// the sum strobe lives in the data path so it stays tied low here
bind exe_ctrl ngram_exec_props ctrl_props (
    .clk       (clk),
    .rst       (rst),
    .k_init    (k_init),
    .out_busy  (out_busy),
    .exec      (exec),
    .s_fin     (s_fin),
    .sum_valid (1'b0),
    .out_fin   (out_fin)
);

// writer side, only the commit timing is watched
bind result_writer ngram_exec_props wr_props (
    .clk       (clk),
    .rst       (rst),
    .k_init    (1'b0),
    .out_busy  (out_busy_o),
    .exec      (1'b0),
    .s_fin     (1'b0),
    .sum_valid (sum_valid_i),
    .out_fin   (out_fin_o)
);

`default_nettype wire

// ==== tests/ngram_exec_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module ngram_exec_tb;

    localparam int NUM_CASES   = 6;
    localparam int FILL_RAND   = 0;
    localparam int FILL_INDEX  = 1;
    localparam int FILL_ONES   = 2;
    localparam int IDLE_CYCLES = 8;

    // one row of the stimulus table
    typedef struct packed {
        int bound_i;
        int bound_j;
        int fill;
        int pulses;
    } case_t;

    logic                   clk = 1'b0;
    logic                   rst;
    logic                   ld_we_i;
    ngram_pkg::addr_t       ld_addr_i;
    ngram_pkg::word_t       ld_data_i;
    logic                   s_init_i;
    ngram_pkg::addr_t       addr_i_i;
    ngram_pkg::addr_t       addr_j_i;
    ngram_pkg::dst_addr_t   rd_addr_i;
    ngram_pkg::word_t       rd_data_o;
    logic                   s_fin_o;

    case_t              cases [NUM_CASES];
    // mirror of the source buffer
    ngram_pkg::word_t   model [ngram_pkg::SRC_DEPTH];
    integer             seed = 32'h16e4;
    int                 cycle_cnt = 0;
    int                 cycle_limit = 0;
    int                 fin_cnt = 0;
    int                 word_errs = 0;
    int                 flag_errs = 0;
    int                 count_errs = 0;

    ngram_exec_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .ld_we_i   (ld_we_i),
        .ld_addr_i (ld_addr_i),
        .ld_data_i (ld_data_i),
        .s_init_i  (s_init_i),
        .addr_i_i  (addr_i_i),
        .addr_j_i  (addr_j_i),
        .rd_addr_i (rd_addr_i),
        .rd_data_o (rd_data_o),
        .s_fin_o   (s_fin_o)
    );

    always #10 clk = ~clk;

    ////////////////////
    // watchdog and s_fin pulse count
    ////////////////////
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("timeout after %0d cycles while waiting for the run to end", cycle_cnt);
            $display("*** FAILED ***");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (s_fin_o) begin
            fin_cnt <= fin_cnt + 1;
        end
    end

    task automatic check_word(input string name, input ngram_pkg::word_t exp,
                              input ngram_pkg::word_t act);
        if (act !== exp) begin
            word_errs++;
            $display("** Error at %0t: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            flag_errs++;
            $display("** Error at %0t: %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            count_errs++;
            $display("** Error at %0t: %s expected %0d got %0d", $time, name, exp, act);
        end
    endtask

    // host load, one word per cycle from address 0
    task automatic load_words(input int count, input int fill);
        ngram_pkg::word_t w;
        for (int a = 0; a < count; a++) begin
            case (fill)
                FILL_RAND:  w = $random(seed);
                FILL_INDEX: w = ngram_pkg::word_t'(a) * 32'h0001_0003 + 32'h0000_0011;
                // close to all ones so every window sum wraps
                default:    w = ~ngram_pkg::word_t'(a);
            endcase
            model[a]  = w;
            ld_we_i   = 1'b1;
            ld_addr_i = ngram_pkg::addr_t'(a);
            ld_data_i = w;
            @(negedge clk);
        end
        ld_we_i = 1'b0;
    endtask

    // slot value from the n-gram rule, wraps mod 2^32
    function automatic ngram_pkg::word_t window_sum(input int slot, input int last_j);
        ngram_pkg::word_t acc;
        acc = '0;
        for (int j = 0; j <= last_j; j++) begin
            acc = acc + model[slot * ngram_pkg::STRIDE + j];
        end
        return acc;
    endfunction

    initial begin
        int c;
        int s;
        int ai;
        int aj;
        int base;
        // bounds, fill mode, expected s_fin pulses
        cases[0] = '{0, 0, FILL_RAND, 1};
        // windows overlap
        cases[1] = '{5, 4, FILL_RAND, 1};
        // many short windows against the busy writer
        cases[2] = '{24, 1, FILL_INDEX, 1};
        // one-word windows, every i step lands while the writer is busy
        cases[3] = '{16, 0, FILL_RAND, 1};
        cases[4] = '{6, 5, FILL_ONES, 1};
        // smaller run overwrites the low slots
        cases[5] = '{3, 2, FILL_INDEX, 1};

        cycle_limit = 3 + IDLE_CYCLES + 16;
        for (c = 0; c < NUM_CASES; c++) begin
            ai = cases[c].bound_i;
            aj = cases[c].bound_j;
            cycle_limit += 4 * (ai + 1) * (aj + 8) + ai * ngram_pkg::STRIDE + aj + 1;
            cycle_limit += 2 * (ai + 1) + 8;
        end

        rst       = 1'b1;
        ld_we_i   = 1'b0;
        ld_addr_i = '0;
        ld_data_i = '0;
        s_init_i  = 1'b0;
        addr_i_i  = '0;
        addr_j_i  = '0;
        rd_addr_i = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // quiet after reset
        for (s = 0; s < IDLE_CYCLES; s++) begin
            @(negedge clk);
            check_flag("s_fin_o", 1'b0, s_fin_o);
        end
        check_count("s_fin_o pulses before the first run", 0, fin_cnt);

        ////////////////////
        // case loop
        ////////////////////
        for (c = 0; c < NUM_CASES; c++) begin
            ai = cases[c].bound_i;
            aj = cases[c].bound_j;
            load_words(ai * ngram_pkg::STRIDE + aj + 1, cases[c].fill);

            addr_i_i = ngram_pkg::addr_t'(ai);
            addr_j_i = ngram_pkg::addr_t'(aj);
            base     = fin_cnt;
            s_init_i = 1'b1;
            @(negedge clk);
            s_init_i = 1'b0;
            while (s_fin_o !== 1'b1) begin
                @(negedge clk);
            end
            // pulse gone and no second one
            repeat (4) @(negedge clk);
            check_flag("s_fin_o", 1'b0, s_fin_o);
            check_count("s_fin_o pulses", cases[c].pulses, fin_cnt - base);

            // readback with one cycle of latency
            for (s = 0; s <= ai; s++) begin
                rd_addr_i = ngram_pkg::dst_addr_t'(s);
                @(negedge clk);
                check_word($sformatf("rd_data_o[%0d]", s), window_sum(s, aj), rd_data_o);
            end
        end

        $display("errors: %0d word, %0d flag, %0d count", word_errs, flag_errs, count_errs);
        if (word_errs + flag_errs + count_errs == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== ngram_exec_top.f ====
source/ngram_pkg.sv
source/agu_next.sv
source/exe_ctrl.sv
source/src_buff.sv
source/window_acc.sv
source/result_writer.sv
source/ngram_exec_top.sv
tests/ngram_exec_props.sv
tests/ngram_exec_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the n-gram core testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f ngram_exec_top.f \
    --top-module ngram_exec_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vngram_exec_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    exit 0
fi
echo "pass message not found in sim.log"
exit 1
